/* hdl/decoder_stage_pkg.sv */
package decoder_stage_pkg;

    // Global decoder stage, issued by the controller to every PE and link
    typedef enum logic [2:0] {
        STAGE_IDLE               = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW               = 3'd2,
        STAGE_MERGE              = 3'd3,
        STAGE_PEELING            = 3'd4,
        STAGE_RESULT             = 3'd5
    } stage_t;

    // Grow rounds after which peeling is forced
    localparam int MAX_GROW_ROUNDS = 32;

    // Merge cycles before the combined busy flag is trusted
    // Stage register inside each PE plus one cycle of propagation
    localparam int MERGE_SETTLE_CYCLES = 3;

endpackage

/* hdl/growth_link.sv */
`timescale 1ns/100ps

module growth_link (
    input  logic                      clk,
    input  logic                      reset,
    input  decoder_stage_pkg::stage_t global_stage,
    input  logic                      increase_a,
    input  logic                      increase_b,
    input  logic                      error_a,
    input  logic                      error_b,
    output logic                      fully_grown,
    output logic                      correction_bit
);
    import decoder_stage_pkg::*;
    import lattice_pkg::*;

    localparam int COUNT_WIDTH = $clog2(LINK_WEIGHT + 1);
    localparam int SUM_WIDTH = COUNT_WIDTH + 1;
    localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(LINK_WEIGHT);

    logic [COUNT_WIDTH-1:0] growth;
    logic [SUM_WIDTH-1:0]   growth_sum;

    // Both ends may grow in the same cycle
    assign growth_sum = SUM_WIDTH'(growth) + SUM_WIDTH'(increase_a) + SUM_WIDTH'(increase_b);

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= '0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            growth <= '0;
        end else if (growth_sum >= SUM_WIDTH'(LINK_WEIGHT)) begin
            growth <= FULL_COUNT;
        end else begin
            growth <= growth_sum[COUNT_WIDTH-1:0];
        end
    end

    assign fully_grown = (growth == FULL_COUNT);

    // Either end may claim this edge while peeling
    assign correction_bit = (global_stage == STAGE_PEELING) && (error_a || error_b);

endmodule

/* hdl/lattice_pkg.sv */
package lattice_pkg;

    // Root address width, top bit set for PEs and clear for boundary roots
    localparam int ADDRESS_WIDTH = 6;

    // One-dimensional line, so each PE sees a left and a right neighbour
    localparam int NUM_DIRECTIONS = 2;
    localparam int DIR_LEFT = 0;
    localparam int DIR_RIGHT = 1;

    // Growth count of a fully grown link, one step from each side
    localparam int LINK_WEIGHT = 2;

    // State a PE shows to one neighbour
    typedef struct packed {
        logic [ADDRESS_WIDTH-1:0] root;
        logic                     parent;   // Receiver is the sender's parent
        logic                     odd;
        logic                     parity;   // Subtree parity of the sender
    } pe_exchange_t;

endpackage

/* hdl/processing_unit.sv */
`timescale 1ns/100ps

module processing_unit (
    input  logic                                              clk,
    input  logic                                              reset,
    input  decoder_stage_pkg::stage_t                         global_stage,
    input  logic                                              measurement,
    input  logic [lattice_pkg::ADDRESS_WIDTH-1:0]             address,
    input  lattice_pkg::pe_exchange_t [lattice_pkg::NUM_DIRECTIONS-1:0] neighbor_in,
    input  logic [lattice_pkg::NUM_DIRECTIONS-1:0]            neighbor_fully_grown,
    input  logic [lattice_pkg::NUM_DIRECTIONS-1:0]            neighbor_is_boundary,
    output lattice_pkg::pe_exchange_t [lattice_pkg::NUM_DIRECTIONS-1:0] neighbor_out,
    output logic [lattice_pkg::NUM_DIRECTIONS-1:0]            neighbor_increase,
    output logic [lattice_pkg::NUM_DIRECTIONS-1:0]            neighbor_is_error,
    output logic                                              odd,
    output logic                                              busy
);
    import decoder_stage_pkg::*;
    import lattice_pkg::*;

    stage_t stage;
    stage_t last_stage;

    logic                      m;
    logic [ADDRESS_WIDTH-1:0]  root;
    logic [NUM_DIRECTIONS-1:0] parent_vector;
    logic                      cluster_parity;

    logic [NUM_DIRECTIONS-1:0] root_valid;
    logic [NUM_DIRECTIONS-1:0] child_vector;
    logic [NUM_DIRECTIONS-1:0] child_parity;
    logic [NUM_DIRECTIONS-1:0] parent_odd;
    logic [NUM_DIRECTIONS-1:0] best_sel;
    logic [ADDRESS_WIDTH-1:0]  best_root;
    logic [ADDRESS_WIDTH-1:0]  boundary_root;
    logic [ADDRESS_WIDTH-1:0]  next_root;
    logic [NUM_DIRECTIONS-1:0] next_parent;
    logic                      touching_boundary;
    logic                      next_parity;
    logic                      next_odd;
    logic                      grow_edge;
    logic [NUM_DIRECTIONS-1:0] error_internal;
    logic [NUM_DIRECTIONS-1:0] error_border;

    // PE acts one cycle after the controller
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            last_stage <= STAGE_IDLE;
        end else begin
            stage <= global_stage;
            last_stage <= stage;
        end
    end

    always_comb begin
        for (int d = 0; d < NUM_DIRECTIONS; d++) begin
            root_valid[d] = neighbor_fully_grown[d] & ~neighbor_is_boundary[d];
            child_vector[d] = neighbor_in[d].parent;
            child_parity[d] = neighbor_in[d].parity;
            parent_odd[d] = neighbor_in[d].odd;
            neighbor_out[d] = '{root: root, parent: parent_vector[d], odd: odd,
                                parity: cluster_parity};
        end
    end

    assign touching_boundary = |neighbor_is_boundary;
    assign boundary_root = touching_boundary ? {1'b0, address[ADDRESS_WIDTH-2:0]} : root;

    // Two-way minimum over valid neighbour roots, left wins a tie
    always_comb begin
        best_sel = '0;
        best_root = neighbor_in[DIR_LEFT].root;
        if (root_valid[DIR_LEFT] && (!root_valid[DIR_RIGHT] ||
                neighbor_in[DIR_LEFT].root <= neighbor_in[DIR_RIGHT].root)) begin
            best_sel[DIR_LEFT] = 1'b1;
        end else if (root_valid[DIR_RIGHT]) begin
            best_sel[DIR_RIGHT] = 1'b1;
            best_root = neighbor_in[DIR_RIGHT].root;
        end
    end

    always_comb begin
        next_root = root;
        next_parent = parent_vector;
        if ((|best_sel) && best_root < boundary_root && best_root < root) begin
            next_root = best_root;
            next_parent = best_sel;
        end else if (boundary_root < root) begin
            next_root = boundary_root;
            next_parent = '0;
        end
    end

    // Subtree parity from the children, odd from the parent or from the root itself
    assign next_parity = (^(child_vector & child_parity)) ^ m;
    assign next_odd = (|parent_vector) ? |(parent_vector & parent_odd)
                                       : next_parity & ~touching_boundary;

    always_ff @(posedge clk) begin
        if (stage == STAGE_MEASUREMENT_LOADING) begin
            m <= measurement;
            root <= address;
            parent_vector <= '0;
            cluster_parity <= measurement;
        end else if (stage == STAGE_MERGE) begin
            root <= next_root;
            parent_vector <= next_parent;
            cluster_parity <= next_parity;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            odd <= 1'b0;
            busy <= 1'b0;
        end else if (stage == STAGE_MEASUREMENT_LOADING) begin
            odd <= measurement;
        end else if (stage == STAGE_MERGE) begin
            odd <= next_odd;
            busy <= (next_root != root) || (next_parity != cluster_parity) ||
                    (next_odd != odd);
        end
    end

    // One growth step per grow stage, on its first cycle
    assign grow_edge = (stage == STAGE_GROW) && (last_stage != STAGE_GROW);
    assign neighbor_increase = {NUM_DIRECTIONS{grow_edge & odd}};

    // Odd subtree flips the link to its parent
    assign error_internal = (stage == STAGE_PEELING && cluster_parity) ? parent_vector : '0;

    // Odd root on a boundary pairs with the boundary
    always_comb begin
        error_border = '0;
        if (stage == STAGE_PEELING && !(|parent_vector) && cluster_parity) begin
            if (neighbor_is_boundary[DIR_LEFT]) begin
                error_border[DIR_LEFT] = 1'b1;
            end else if (neighbor_is_boundary[DIR_RIGHT]) begin
                error_border[DIR_RIGHT] = 1'b1;
            end
        end
    end

    assign neighbor_is_error = error_internal | error_border;

endmodule

/* hdl/stage_controller.sv */
`timescale 1ns/100ps

module stage_controller #(
    parameter int NUM_PES = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic [NUM_PES-1:0]        syndrome,
    input  logic [NUM_PES-1:0]        pe_busy,
    input  logic [NUM_PES-1:0]        pe_odd,
    input  logic [NUM_PES:0]          link_error,
    output decoder_stage_pkg::stage_t global_stage,
    output logic [NUM_PES-1:0]        loaded_syndrome,
    output logic [NUM_PES:0]          correction,
    output logic                      done,
    output logic                      busy
);
    import decoder_stage_pkg::*;

    localparam int STEP_WIDTH = $clog2(MERGE_SETTLE_CYCLES + 1);
    localparam int ROUND_WIDTH = $clog2(MAX_GROW_ROUNDS + 1);
    localparam logic [STEP_WIDTH-1:0] LAST_SETTLE_STEP = STEP_WIDTH'(MERGE_SETTLE_CYCLES - 1);
    localparam logic [ROUND_WIDTH-1:0] ROUND_LIMIT = ROUND_WIDTH'(MAX_GROW_ROUNDS);

    logic [STEP_WIDTH-1:0]  step;
    logic [ROUND_WIDTH-1:0] grow_rounds;
    logic                   any_busy;
    logic                   any_odd;
    logic                   rounds_left;

    assign any_busy = |pe_busy;
    assign any_odd = |pe_odd;
    assign rounds_left = grow_rounds < ROUND_LIMIT;

    always_ff @(posedge clk) begin
        if (reset) begin
            global_stage <= STAGE_IDLE;
            step <= '0;
            grow_rounds <= '0;
            correction <= '0;
        end else begin
            case (global_stage)
                STAGE_IDLE: begin
                    if (start) begin
                        global_stage <= STAGE_MEASUREMENT_LOADING;
                        grow_rounds <= '0;
                    end
                end
                STAGE_MEASUREMENT_LOADING: begin
                    global_stage <= STAGE_GROW;
                    step <= '0;
                end
                // Two cycles so the PE edge detector fires once
                STAGE_GROW: begin
                    if (step == '0) begin
                        step <= STEP_WIDTH'(1);
                    end else begin
                        step <= '0;
                        grow_rounds <= grow_rounds + ROUND_WIDTH'(1);
                        global_stage <= STAGE_MERGE;
                    end
                end
                // Busy lags the stage by two cycles, so wait before trusting it
                STAGE_MERGE: begin
                    if (step != LAST_SETTLE_STEP) begin
                        step <= step + STEP_WIDTH'(1);
                    end else if (!any_busy) begin
                        step <= '0;
                        global_stage <= (any_odd && rounds_left) ? STAGE_GROW : STAGE_PEELING;
                    end
                end
                // PE error flags show up in the second cycle
                STAGE_PEELING: begin
                    if (step == '0) begin
                        step <= STEP_WIDTH'(1);
                    end else begin
                        step <= '0;
                        correction <= link_error;
                        global_stage <= STAGE_RESULT;
                    end
                end
                STAGE_RESULT: begin
                    global_stage <= STAGE_IDLE;
                end
                default: begin
                    global_stage <= STAGE_IDLE;
                end
            endcase
        end
    end

    // Syndrome sampled only on an accepted start
    always_ff @(posedge clk) begin
        if (global_stage == STAGE_IDLE && start) begin
            loaded_syndrome <= syndrome;
        end
    end

    assign done = (global_stage == STAGE_RESULT);
    assign busy = (global_stage != STAGE_IDLE);

endmodule

/* hdl/uf_decoder_top.sv */
`timescale 1ns/100ps

module uf_decoder_top #(
    parameter int NUM_PES = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [NUM_PES-1:0] syndrome,
    output logic [NUM_PES:0]   correction,
    output logic               done,
    output logic               busy
);
    import decoder_stage_pkg::*;
    import lattice_pkg::*;

    localparam int INDEX_WIDTH = ADDRESS_WIDTH - 1;

    stage_t             global_stage;
    logic [NUM_PES-1:0] loaded_syndrome;
    logic [NUM_PES-1:0] pe_busy;
    logic [NUM_PES-1:0] pe_odd;

    // Per link k: side a is PE k-1, side b is PE k
    logic [NUM_PES:0]   link_error;
    logic [NUM_PES:0]   link_full;
    logic [NUM_PES:0]   increase_a;
    logic [NUM_PES:0]   increase_b;
    logic [NUM_PES:0]   error_a;
    logic [NUM_PES:0]   error_b;

    // Exchange crossing link k in each direction
    pe_exchange_t [NUM_PES:0] exchange_rightward;
    pe_exchange_t [NUM_PES:0] exchange_leftward;

    stage_controller #(
        .NUM_PES(NUM_PES)
    ) stage_controller_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .syndrome(syndrome),
        .pe_busy(pe_busy),
        .pe_odd(pe_odd),
        .link_error(link_error),
        .global_stage(global_stage),
        .loaded_syndrome(loaded_syndrome),
        .correction(correction),
        .done(done),
        .busy(busy)
    );

    // Boundaries never grow, never flag and show no state
    assign exchange_rightward[0] = '0;
    assign exchange_leftward[NUM_PES] = '0;
    assign increase_a[0] = 1'b0;
    assign increase_b[NUM_PES] = 1'b0;
    assign error_a[0] = 1'b0;
    assign error_b[NUM_PES] = 1'b0;

    for (genvar i = 0; i < NUM_PES; i++) begin : gen_pe
        localparam logic [ADDRESS_WIDTH-1:0] PE_ADDRESS = {1'b1, INDEX_WIDTH'(i)};

        pe_exchange_t [NUM_DIRECTIONS-1:0] pe_in;
        pe_exchange_t [NUM_DIRECTIONS-1:0] pe_out;
        logic [NUM_DIRECTIONS-1:0]         pe_full;
        logic [NUM_DIRECTIONS-1:0]         pe_boundary;
        logic [NUM_DIRECTIONS-1:0]         pe_increase;
        logic [NUM_DIRECTIONS-1:0]         pe_error;

        assign pe_in[DIR_LEFT] = exchange_rightward[i];
        assign pe_in[DIR_RIGHT] = exchange_leftward[i+1];
        assign exchange_leftward[i] = pe_out[DIR_LEFT];
        assign exchange_rightward[i+1] = pe_out[DIR_RIGHT];

        assign pe_full[DIR_LEFT] = link_full[i];
        assign pe_full[DIR_RIGHT] = link_full[i+1];
        // Only the end PEs sit next to a boundary link
        assign pe_boundary[DIR_LEFT] = (i == 0) ? link_full[0] : 1'b0;
        assign pe_boundary[DIR_RIGHT] = (i == NUM_PES - 1) ? link_full[NUM_PES] : 1'b0;

        assign increase_b[i] = pe_increase[DIR_LEFT];
        assign increase_a[i+1] = pe_increase[DIR_RIGHT];
        assign error_b[i] = pe_error[DIR_LEFT];
        assign error_a[i+1] = pe_error[DIR_RIGHT];

        processing_unit processing_unit_inst (
            .clk(clk),
            .reset(reset),
            .global_stage(global_stage),
            .measurement(loaded_syndrome[i]),
            .address(PE_ADDRESS),
            .neighbor_in(pe_in),
            .neighbor_fully_grown(pe_full),
            .neighbor_is_boundary(pe_boundary),
            .neighbor_out(pe_out),
            .neighbor_increase(pe_increase),
            .neighbor_is_error(pe_error),
            .odd(pe_odd[i]),
            .busy(pe_busy[i])
        );
    end

    for (genvar k = 0; k <= NUM_PES; k++) begin : gen_link
        growth_link growth_link_inst (
            .clk(clk),
            .reset(reset),
            .global_stage(global_stage),
            .increase_a(increase_a[k]),
            .increase_b(increase_b[k]),
            .error_a(error_a[k]),
            .error_b(error_b[k]),
            .fully_grown(link_full[k]),
            .correction_bit(link_error[k])
        );
    end

endmodule

/* project.f */
hdl/decoder_stage_pkg.sv
hdl/lattice_pkg.sv
hdl/processing_unit.sv
hdl/growth_link.sv
hdl/stage_controller.sv
hdl/uf_decoder_top.sv
testbench/uf_decoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the fail message in the log
verilator --binary --timing -Wno-fatal -f project.f --top-module uf_decoder_tb \
    -o uf_decoder_sim > build.log 2>&1 \
    && ./obj_dir/uf_decoder_sim > sim.log 2>&1 \
    && ! grep -q "Errors found" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

/* testbench/uf_decoder_tb.sv */
`timescale 1ns/100ps

module uf_decoder_tb;

    localparam int NUM_PES = 8;
    localparam int TABLE_SIZE = 7;
    localparam int RANDOM_COUNT = 20;
    localparam int DONE_TIMEOUT = 2000;
    localparam int HOLD_CYCLES = 20;

    // One table entry, applied syndrome and the correction it must give
    typedef struct packed {
        logic [NUM_PES-1:0] syndrome;
        logic [NUM_PES:0]   correction;
    } test_vector_t;

    logic               clk;
    logic               reset;
    logic               start;
    logic [NUM_PES-1:0] syndrome;
    logic [NUM_PES:0]   correction;
    logic               done;
    logic               busy;

    test_vector_t vector_table [TABLE_SIZE];
    int           error_count;
    int           test_count;
    int           done_pulses;
    int           seed;

    uf_decoder_top #(
        .NUM_PES(NUM_PES)
    ) uf_decoder_top_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .syndrome(syndrome),
        .correction(correction),
        .done(done),
        .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Count every done pulse on the falling edge
    always @(negedge clk) begin
        if (done) begin
            done_pulses++;
        end
    end

    task automatic check_correction(input logic [NUM_PES:0] actual,
                                    input logic [NUM_PES:0] expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s correction %b, expected %b", $time, what, actual,
                     expected);
        end
    endtask

    // Bit i of the syndrome is the parity of the two links around PE i
    task automatic check_syndrome_match(input logic [NUM_PES-1:0] applied,
                                        input logic [NUM_PES:0] actual, input string what);
        logic [NUM_PES-1:0] recomputed;
        for (int i = 0; i < NUM_PES; i++) begin
            recomputed[i] = actual[i] ^ actual[i+1];
        end
        if (recomputed !== applied) begin
            error_count++;
            $display("FAILED at %0t: %s correction %b gives syndrome %b, applied %b", $time,
                     what, actual, recomputed, applied);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            error_count++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic pulse_start(input logic [NUM_PES-1:0] value);
        @(posedge clk);
        #1;
        start = 1'b1;
        syndrome = value;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_for_done(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            if (done) begin
                seen = 1'b1;
            end
            cycles++;
        end
        if (!seen) begin
            error_count++;
            $display("Timeout at %0t: done never arrived within %0d cycles", $time,
                     DONE_TIMEOUT);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: mismatch", test_count, name);
        end
    endtask

    initial begin
        logic [NUM_PES-1:0] random_syndrome;
        bit                 seen;
        int                 errors_before;
        int                 pulses_before;

        error_count = 0;
        test_count = 0;
        done_pulses = 0;
        seed = 10;
        reset = 1'b1;
        start = 1'b0;
        syndrome = '0;

        vector_table[0] = '{syndrome: 8'h00, correction: 9'h000};
        vector_table[1] = '{syndrome: 8'h03, correction: 9'h002};
        vector_table[2] = '{syndrome: 8'h0c, correction: 9'h008};
        vector_table[3] = '{syndrome: 8'h60, correction: 9'h040};
        vector_table[4] = '{syndrome: 8'hc0, correction: 9'h080};
        vector_table[5] = '{syndrome: 8'h01, correction: 9'h001};
        vector_table[6] = '{syndrome: 8'h80, correction: 9'h100};

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        errors_before = error_count;
        @(negedge clk);
        check_flag(done, 1'b0, "done after reset");
        check_flag(busy, 1'b0, "busy after reset");
        check_correction(correction, '0, "after reset");
        report_test("reset state", errors_before);

        for (int t = 0; t < TABLE_SIZE; t++) begin
            errors_before = error_count;
            pulse_start(vector_table[t].syndrome);
            wait_for_done(seen);
            if (seen) begin
                check_correction(correction, vector_table[t].correction,
                                 $sformatf("table entry %0d", t));
            end
            report_test($sformatf("table entry %0d", t), errors_before);
        end

        for (int r = 0; r < RANDOM_COUNT; r++) begin
            errors_before = error_count;
            random_syndrome = NUM_PES'($random(seed));
            pulse_start(random_syndrome);
            wait_for_done(seen);
            if (seen) begin
                check_syndrome_match(random_syndrome, correction,
                                     $sformatf("random %0d", r));
            end
            report_test($sformatf("random syndrome %0d", r), errors_before);
        end

        // Second start lands while the first decode is still running
        errors_before = error_count;
        pulse_start(vector_table[2].syndrome);
        pulses_before = done_pulses;
        @(posedge clk);
        #1;
        check_flag(busy, 1'b1, "busy before second start");
        start = 1'b1;
        syndrome = vector_table[3].syndrome;
        @(posedge clk);
        #1;
        start = 1'b0;
        wait_for_done(seen);
        if (seen) begin
            check_correction(correction, vector_table[2].correction, "start while busy");
        end
        repeat (10) @(negedge clk);
        check_count(done_pulses - pulses_before, 1, "done pulses after start while busy");
        report_test("start while busy", errors_before);

        // Correction holds until the next accepted start
        errors_before = error_count;
        for (int h = 0; h < HOLD_CYCLES; h++) begin
            @(negedge clk);
            check_correction(correction, vector_table[2].correction, "held result");
            check_flag(done, 1'b0, "done while idle");
            check_flag(busy, 1'b0, "busy while idle");
        end
        pulse_start(vector_table[5].syndrome);
        wait_for_done(seen);
        if (seen) begin
            check_correction(correction, vector_table[5].correction, "after hold");
        end
        report_test("hold until next start", errors_before);

        $display("Tests run: %0d, failed checks: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
